// ==== filelist.f ====
logic/CoreTypesPkg.sv
logic/PhtTypesPkg.sv
logic/MultiBankPht.sv
logic/QueuePointer.sv
logic/BimodalPredictor.sv
logic/BranchPredictTop.sv
verif/BimodalTb.sv

// ==== logic/BimodalPredictor.sv ====
// Bimodal branch direction predictor
// Slot-wise prediction up to the first taken slot, saturating counter update,
// bank conflict queue and the post-reset init sequencer

`timescale 1ns/1ps
`default_nettype none

module BimodalPredictor #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int entryNum = 64,
    parameter int queueSize = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  CoreTypesPkg::pcWord      predNextPc,
    input  logic                     btbHit [fetchWidth],
    input  logic                     brValid [issueWidth],
    input  CoreTypesPkg::pcWord      brAddr [issueWidth],
    input  logic                     brTaken [issueWidth],
    input  PhtTypesPkg::phtCounter   brPrevValue [issueWidth],
    output logic                     brPredTaken [fetchWidth],
    output PhtTypesPkg::phtCounter   phtPrevValue [fetchWidth],
    output logic                     initBusy
);
    import CoreTypesPkg::*;
    import PhtTypesPkg::*;

    localparam int indexBits = $clog2(entryNum);
    localparam int bankBits = $clog2(issueWidth);
    localparam int ptrBits = $clog2(queueSize);

    function automatic logic [indexBits-1:0] toIndex(pcWord addr);
        return addr[indexBits+insnAddrBits-1:insnAddrBits];
    endfunction

    function automatic logic sameBank(logic [indexBits-1:0] a, logic [indexBits-1:0] b);
        return a[bankBits-1:0] == b[bankBits-1:0];
    endfunction

    // Saturating up/down step
    function automatic phtCounter nextCounter(phtCounter prev, logic taken);
        if (taken) begin
            return (prev == phtCounterMax) ? phtCounterMax : prev + 1'b1;
        end
        return (prev == phtCounterMin) ? phtCounterMin : prev - 1'b1;
    endfunction

    // Table ports
    logic tableWe [issueWidth];
    logic [indexBits-1:0] tableWa [issueWidth];
    phtCounter tableWv [issueWidth];
    logic [indexBits-1:0] phtRa [fetchWidth];

    // Conflict queue
    logic pushQueue;
    logic popQueue;
    logic queueFull;
    logic queueEmpty;
    logic [ptrBits-1:0] headPtr;
    logic [ptrBits-1:0] tailPtr;
    logic [indexBits-1:0] pushWa;
    phtCounter pushWv;
    logic [indexBits-1:0] queueWa [queueSize];
    phtCounter queueWv [queueSize];

    logic [indexBits-1:0] initIndex;

    MultiBankPht #(
        .entryNum(entryNum),
        .bankNum(issueWidth),
        .readNum(fetchWidth)
    ) pht (
        .clk(clk),
        .we(tableWe),
        .wa(tableWa),
        .wv(tableWv),
        .ra(phtRa),
        .rv(phtPrevValue)
    );

    QueuePointer #(
        .size(queueSize)
    ) phtQueuePointer (
        .clk(clk),
        .rst(rst),
        .push(pushQueue),
        .pop(popQueue),
        .full(queueFull),
        .empty(queueEmpty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Walk every entry once after reset, one per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            initIndex <= '0;
            initBusy <= 1'b1;
        end else if (initBusy) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == indexBits'(entryNum - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

    // Storage follows the pointer module, which drops pushes when full
    always_ff @(posedge clk) begin
        if (pushQueue && !queueFull) begin
            queueWa[tailPtr] <= pushWa;
            queueWv[tailPtr] <= pushWv;
        end
    end

    // Read consecutive slots, value comes back next cycle
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            phtRa[i] = toIndex(predNextPc + pcWord'(i * insnByteWidth));
        end
    end

    // Taken needs the counter MSB and a BTB hit; later slots are cut off
    always_comb begin : predictBlock
        logic takenSeen;
        takenSeen = 1'b0;
        for (int i = 0; i < fetchWidth; i++) begin
            brPredTaken[i] = !takenSeen && !initBusy &&
                phtPrevValue[i][phtCounterWidth-1] && btbHit[i];
            if (brPredTaken[i]) begin
                takenSeen = 1'b1;
            end
        end
    end

    always_comb begin : writeBlock
        logic headBlocked;
        headBlocked = 1'b0;

        // Direct updates from resolved branches
        for (int i = 0; i < issueWidth; i++) begin
            tableWe[i] = brValid[i];
            tableWa[i] = toIndex(brAddr[i]);
            tableWv[i] = nextCounter(brPrevValue[i], brTaken[i]);
        end

        // An update colliding with an earlier port's bank goes to the queue;
        // only one push per cycle
        pushQueue = 1'b0;
        pushWa = '0;
        pushWv = '0;
        for (int i = 1; i < issueWidth; i++) begin
            for (int j = 0; j < i; j++) begin
                if (tableWe[i] && tableWe[j] && sameBank(tableWa[i], tableWa[j])) begin
                    tableWe[i] = 1'b0;
                    if (!pushQueue) begin
                        pushQueue = 1'b1;
                        pushWa = tableWa[i];
                        pushWv = tableWv[i];
                    end
                end
            end
        end

        // Retry the head on an idle port if its bank is free this cycle
        popQueue = 1'b0;
        if (!queueEmpty) begin
            for (int j = 0; j < issueWidth; j++) begin
                if (tableWe[j] && sameBank(tableWa[j], queueWa[headPtr])) begin
                    headBlocked = 1'b1;
                end
            end
            for (int i = 0; i < issueWidth; i++) begin
                if (!headBlocked && !popQueue && !tableWe[i]) begin
                    popQueue = 1'b1;
                    tableWe[i] = 1'b1;
                    tableWa[i] = queueWa[headPtr];
                    tableWv[i] = queueWv[headPtr];
                end
            end
        end

        // Init owns port 0, everything else waits
        if (initBusy) begin
            for (int i = 0; i < issueWidth; i++) begin
                tableWe[i] = (i == 0);
                tableWa[i] = initIndex;
                tableWv[i] = phtInitValue;
            end
            pushQueue = 1'b0;
            popQueue = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/BranchPredictTop.sv ====
// Branch predictor top level
// Sets the predictor configuration and instantiates the bimodal predictor

`timescale 1ns/1ps
`default_nettype none

module BranchPredictTop #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int entryNum = 64,
    parameter int queueSize = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  CoreTypesPkg::pcWord      predNextPc,
    input  logic                     btbHit [fetchWidth],
    input  logic                     brValid [issueWidth],
    input  CoreTypesPkg::pcWord      brAddr [issueWidth],
    input  logic                     brTaken [issueWidth],
    input  PhtTypesPkg::phtCounter   brPrevValue [issueWidth],
    output logic                     brPredTaken [fetchWidth],
    output PhtTypesPkg::phtCounter   phtPrevValue [fetchWidth],
    output logic                     initBusy
);

    BimodalPredictor #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .entryNum(entryNum),
        .queueSize(queueSize)
    ) predictor (
        .clk(clk),
        .rst(rst),
        .predNextPc(predNextPc),
        .btbHit(btbHit),
        .brValid(brValid),
        .brAddr(brAddr),
        .brTaken(brTaken),
        .brPrevValue(brPrevValue),
        .brPredTaken(brPredTaken),
        .phtPrevValue(phtPrevValue),
        .initBusy(initBusy)
    );

endmodule

`default_nettype wire

// ==== logic/CoreTypesPkg.sv ====
// Core addressing package
// Program counter word type and instruction addressing constants

`default_nettype none

package CoreTypesPkg;

    // Byte address of an instruction
    localparam int pcWidth = 32;
    typedef logic [pcWidth-1:0] pcWord;

    // Fixed-length instructions
    localparam int insnByteWidth = 4;

    // Low PC bits below the instruction index
    localparam int insnAddrBits = 2;

endpackage

`default_nettype wire

// ==== logic/MultiBankPht.sv ====
// Bank-interleaved counter table
// One write port per bank, routed by the bank bits of the write address,
// and registered read ports that can read from any bank

`timescale 1ns/1ps
`default_nettype none

module MultiBankPht #(
    parameter int entryNum = 64,
    parameter int bankNum = 2,
    parameter int readNum = 2
) (
    input  logic                           clk,
    input  logic                           we [bankNum],
    input  logic [$clog2(entryNum)-1:0]    wa [bankNum],
    input  PhtTypesPkg::phtCounter         wv [bankNum],
    input  logic [$clog2(entryNum)-1:0]    ra [readNum],
    output PhtTypesPkg::phtCounter         rv [readNum]
);
    import PhtTypesPkg::*;

    // Bank is the low index bits, row is the rest
    localparam int indexBits = $clog2(entryNum);
    localparam int bankBits = $clog2(bankNum);
    localparam int rowBits = indexBits - bankBits;
    localparam int rowNum = entryNum / bankNum;

    phtCounter bankMem [bankNum][rowNum];

    // Per-bank write request after routing
    logic bankWe [bankNum];
    logic [rowBits-1:0] bankRow [bankNum];
    phtCounter bankWv [bankNum];

    // Pick the port aimed at each bank; ports never share a bank
    always_comb begin
        for (int b = 0; b < bankNum; b++) begin
            bankWe[b] = 1'b0;
            bankRow[b] = '0;
            bankWv[b] = '0;
            for (int p = 0; p < bankNum; p++) begin
                if (we[p] && wa[p][bankBits-1:0] == bankBits'(b)) begin
                    bankWe[b] = 1'b1;
                    bankRow[b] = wa[p][indexBits-1:bankBits];
                    bankWv[b] = wv[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < bankNum; b++) begin
            if (bankWe[b]) begin
                bankMem[b][bankRow[b]] <= bankWv[b];
            end
        end

        // Reads see writes from earlier edges only
        for (int r = 0; r < readNum; r++) begin
            rv[r] <= bankMem[ra[r][bankBits-1:0]][ra[r][indexBits-1:bankBits]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/PhtTypesPkg.sv ====
// Pattern history table package
// Saturating counter type, counter limits and the value written at init

`default_nettype none

package PhtTypesPkg;

    // 2-bit saturating direction counter, upper bit means taken
    localparam int phtCounterWidth = 2;
    typedef logic [phtCounterWidth-1:0] phtCounter;

    // Saturation limits
    localparam phtCounter phtCounterMax = phtCounter'(3);
    localparam phtCounter phtCounterMin = phtCounter'(0);

    // Weakly taken
    localparam phtCounter phtInitValue = phtCounter'(phtCounterMax / 2 + 1);

endpackage

`default_nettype wire

// ==== logic/QueuePointer.sv ====
// Circular queue pointers
// Head and tail pointers with an occupancy count, full and empty flags

`timescale 1ns/1ps
`default_nettype none

module QueuePointer #(
    parameter int size = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic                     pop,
    output logic                     full,
    output logic                     empty,
    output logic [$clog2(size)-1:0]  headPtr,
    output logic [$clog2(size)-1:0]  tailPtr
);
    localparam int ptrBits = $clog2(size);
    localparam int countBits = $clog2(size + 1);

    logic [countBits-1:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [ptrBits-1:0] nextPtr(logic [ptrBits-1:0] ptr);
        return (ptr == ptrBits'(size - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A push into a full queue is lost
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    assign full = (count == countBits'(size));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (doPop) begin
                headPtr <= nextPtr(headPtr);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the predictor testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module BimodalTb -f filelist.f -o simBimodal \
    && ./obj_dir/simBimodal | tee sim.log \
    && ! grep -q "Simulation finished: FAIL" sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== verif/BimodalTb.sv ====
// Directed testbench for the bimodal branch predictor
// Reference counter model with init, saturation, slot cut-off,
// bank conflict and random traffic tests

`timescale 1ns/1ps
`default_nettype none

module BimodalTb;
    import CoreTypesPkg::*;
    import PhtTypesPkg::*;

    localparam int fetchWidth = 2;
    localparam int issueWidth = 2;
    localparam int entryNum = 64;
    localparam int queueSize = 4;
    localparam int cycleLimit = entryNum + 2000;

    logic clk;
    logic rst;
    pcWord predNextPc;
    logic btbHit [fetchWidth];
    logic brValid [issueWidth];
    pcWord brAddr [issueWidth];
    logic brTaken [issueWidth];
    phtCounter brPrevValue [issueWidth];
    logic brPredTaken [fetchWidth];
    phtCounter phtPrevValue [fetchWidth];
    logic initBusy;

    // Expected table contents
    phtCounter model [entryNum];
    int errorCount;
    int checkCount;
    int cycleCount = 0;

    BranchPredictTop DUT (
        .clk(clk),
        .rst(rst),
        .predNextPc(predNextPc),
        .btbHit(btbHit),
        .brValid(brValid),
        .brAddr(brAddr),
        .brTaken(brTaken),
        .brPrevValue(brPrevValue),
        .brPredTaken(brPredTaken),
        .phtPrevValue(phtPrevValue),
        .initBusy(initBusy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: tests still running after %0d cycles", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic pcWord addrOf(int index);
        return pcWord'(index * insnByteWidth);
    endfunction

    // Count up on taken, down otherwise, clamped to the counter range
    function automatic phtCounter stepCounter(phtCounter value, logic taken);
        int next;
        next = taken ? int'(value) + 1 : int'(value) - 1;
        if (next > int'(phtCounterMax)) begin
            next = int'(phtCounterMax);
        end
        if (next < 0) begin
            next = 0;
        end
        return phtCounter'(next);
    endfunction

    task automatic checkValue(string what, int got, int expected);
        checkCount++;
        assert (got == expected) else begin
            errorCount++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Fetch two slots from index, check counters and the taken cut-off
    task automatic readSlots(int index, logic hit0, logic hit1);
        logic takenSeen;
        logic expectTaken;
        int slot;
        predNextPc = addrOf(index);
        btbHit[0] = hit0;
        btbHit[1] = hit1;
        @(negedge clk);
        takenSeen = 1'b0;
        for (int s = 0; s < fetchWidth; s++) begin
            slot = (index + s) % entryNum;
            expectTaken = !takenSeen && model[slot][phtCounterWidth-1] && btbHit[s];
            checkValue($sformatf("counter %0d", slot), int'(phtPrevValue[s]), int'(model[slot]));
            checkValue($sformatf("prediction slot %0d", s), int'(brPredTaken[s]),
                int'(expectTaken));
            takenSeen = takenSeen || expectTaken;
        end
    endtask

    // One update cycle; indices of valid ports must differ
    task automatic updateBranches(logic valid0, int index0, logic taken0,
                                  logic valid1, int index1, logic taken1);
        brValid[0] = valid0;
        brAddr[0] = addrOf(index0);
        brTaken[0] = taken0;
        brPrevValue[0] = model[index0];
        brValid[1] = valid1;
        brAddr[1] = addrOf(index1);
        brTaken[1] = taken1;
        brPrevValue[1] = model[index1];
        if (valid0) begin
            model[index0] = stepCounter(model[index0], taken0);
        end
        if (valid1) begin
            model[index1] = stepCounter(model[index1], taken1);
        end
        @(negedge clk);
        brValid[0] = 1'b0;
        brValid[1] = 1'b0;
    endtask

    task automatic initTest();
        int cycles;
        cycles = 0;
        // Hits on both slots, so only the busy flag can hold predictions low
        predNextPc = addrOf(0);
        btbHit[0] = 1'b1;
        btbHit[1] = 1'b1;
        rst = 1'b0;
        while (initBusy && cycles <= entryNum + 8) begin
            for (int s = 0; s < fetchWidth; s++) begin
                checkValue($sformatf("prediction slot %0d during init", s),
                    int'(brPredTaken[s]), 0);
            end
            @(negedge clk);
            cycles++;
        end
        checkValue("init cycles", cycles, entryNum);
        for (int i = 0; i < entryNum; i += fetchWidth) begin
            readSlots(i, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
        end
    endtask

    task automatic saturationTest();
        for (int n = 0; n < 4; n++) begin
            updateBranches(1'b1, 16, 1'b1, 1'b0, 0, 1'b0);
            readSlots(16, 1'b1, 1'b1);
        end
        for (int n = 0; n < 5; n++) begin
            updateBranches(1'b1, 16, 1'b0, 1'b0, 0, 1'b0);
            readSlots(16, 1'b1, 1'b1);
        end
    endtask

    task automatic truncationTest();
        updateBranches(1'b1, 30, 1'b1, 1'b1, 31, 1'b1);
        readSlots(30, 1'b1, 1'b1);
        checkValue("slot 1 after taken slot 0", int'(brPredTaken[1]), 0);
        updateBranches(1'b1, 30, 1'b0, 1'b0, 0, 1'b0);
        updateBranches(1'b1, 30, 1'b0, 1'b0, 0, 1'b0);
        readSlots(30, 1'b1, 1'b1);
        checkValue("slot 1 with slot 0 not taken", int'(brPredTaken[1]), 1);
    endtask

    task automatic conflictTest();
        // 10 and 12 share bank 0, the second one is queued
        updateBranches(1'b1, 10, 1'b0, 1'b1, 12, 1'b0);
        repeat (queueSize) @(negedge clk);
        readSlots(10, 1'b0, 1'b0);
        readSlots(12, 1'b0, 1'b0);
        updateBranches(1'b1, 20, 1'b1, 1'b1, 21, 1'b1);
        readSlots(20, 1'b0, 1'b0);
    endtask

    task automatic randomTest();
        int index0;
        int index1;
        logic valid0;
        logic valid1;
        for (int n = 0; n < 250; n++) begin
            index0 = int'($urandom_range(0, entryNum - 1));
            index1 = int'($urandom_range(0, entryNum - 1));
            if (index1 == index0) begin
                index1 = (index0 + 3) % entryNum;
            end
            valid0 = ($urandom_range(0, 3) != 0);
            valid1 = ($urandom_range(0, 3) != 0);
            updateBranches(valid0, index0, 1'($urandom_range(0, 1)),
                valid1, index1, 1'($urandom_range(0, 1)));
            // Let a queued update land before its index can come back
            if (valid0 && valid1 && (index0 % issueWidth) == (index1 % issueWidth)) begin
                repeat (queueSize) @(negedge clk);
            end else begin
                repeat ($urandom_range(0, 2)) @(negedge clk);
            end
        end
        repeat (queueSize) @(negedge clk);
        for (int i = 0; i < entryNum; i += fetchWidth) begin
            readSlots(i, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
        end
    endtask

    initial begin
        void'($urandom(47));
        clk = 1'b0;
        rst = 1'b1;
        predNextPc = '0;
        for (int i = 0; i < fetchWidth; i++) begin
            btbHit[i] = 1'b0;
        end
        for (int p = 0; p < issueWidth; p++) begin
            brValid[p] = 1'b0;
            brAddr[p] = '0;
            brTaken[p] = 1'b0;
            brPrevValue[p] = '0;
        end
        for (int i = 0; i < entryNum; i++) begin
            model[i] = phtInitValue;
        end
        errorCount = 0;
        checkCount = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        initTest();
        saturationTest();
        truncationTest();
        conflictTest();
        randomTest();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
